/* src/pwm_defs.svh */
// PWM widths and register map
`ifndef PWM_DEFS_SVH
`define PWM_DEFS_SVH

// ------------------------------
// Widths
// ------------------------------

// Period and duty values, one word
`define PWM_CNT_W 16

// Host register address
`define PWM_ADDR_W 2

// ------------------------------
// Register addresses
// ------------------------------

// Control register, bit 0 enable, bit 1 idle polarity
`define PWM_ADDR_CTRL 2'd0
// Frame length in clock cycles
`define PWM_ADDR_PERIOD 2'd1
// Active length minus one
`define PWM_ADDR_DUTY 2'd2
// Strobe only, nothing stored
`define PWM_ADDR_COMMIT 2'd3

`endif

/* src/pwm_pkg.sv */
// PWM shared types
`include "pwm_defs.svh"

package pwm_pkg;

	// Period and duty payload
	typedef logic [`PWM_CNT_W-1:0] pwm_cnt_t;

	// Host register map
	typedef enum logic [`PWM_ADDR_W-1:0] {
		reg_ctrl   = `PWM_ADDR_CTRL,
		reg_period = `PWM_ADDR_PERIOD,
		reg_duty   = `PWM_ADDR_DUTY,
		reg_commit = `PWM_ADDR_COMMIT
	} reg_addr_t;

	// Duty cycle FSM states
	// Count drives the output active, wait holds it inactive until frame end
	typedef enum logic [1:0] {
		duty_idle  = 2'd0,
		duty_count = 2'd1,
		duty_wait  = 2'd2
	} duty_state_t;

endpackage

/* src/pwm_regs.sv */
// PWM host register block
`timescale 1ns/1ps
`include "pwm_defs.svh"

module pwm_regs
	import pwm_pkg::*;
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   wr_en,
	input  logic [`PWM_ADDR_W-1:0] wr_addr,
	input  pwm_cnt_t               wr_data,
	output logic                   enable,
	output logic                   idle_pol,
	output pwm_cnt_t               period_val,
	output pwm_cnt_t               duty_val,
	output logic                   commit
);

	// Control register bit positions
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_POL_BIT = 1;

	reg_addr_t wr_reg;

	// Decode the raw address into the register map
	assign wr_reg = reg_addr_t'(wr_addr);

	// ------------------------------
	// Register writes
	// ------------------------------

	// All writes land one cycle after the strobe
	// Upper control bits are dropped
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			enable     <= 1'b0;
			idle_pol   <= 1'b0;
			period_val <= '0;
			duty_val   <= '0;
			commit     <= 1'b0;
		end
		else
		begin
			// Commit is a pulse, high only for the cycle after its write
			commit <= wr_en && (wr_reg == reg_commit);

			if (wr_en)
			begin
				case (wr_reg)
				reg_ctrl:
				begin
					enable   <= wr_data[CTRL_EN_BIT];
					idle_pol <= wr_data[CTRL_POL_BIT];
				end
				reg_period:
					period_val <= wr_data;
				reg_duty:
					duty_val <= wr_data;
				// Commit address stores nothing
				default:
					;
				endcase
			end
		end
	end

endmodule

/* src/period_counter.sv */
// PWM frame period counter
`timescale 1ns/1ps
`include "pwm_defs.svh"

module period_counter
	import pwm_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     enable,
	input  logic     commit,
	input  pwm_cnt_t period_val,
	output logic     freq_tc
);

	// Reload point of the down-counter
	localparam pwm_cnt_t CNT_ONE = `PWM_CNT_W'(1);

	// Period in use for the frames, follows period_val only on commit
	pwm_cnt_t period_shadow;
	// Cycles left in the current frame
	pwm_cnt_t period_cnt;
	// Last cycle of the frame
	logic     period_end;

	// Zero is treated like one so a bad period cannot run away
	assign period_end = (period_cnt <= CNT_ONE);

	// ------------------------------
	// Shadow register
	// ------------------------------

	// Follows the host value while disabled
	// While running it only moves on commit, the running frame keeps its count
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			period_shadow <= '0;
		else if (!enable || commit)
			period_shadow <= period_val;
	end

	// ------------------------------
	// Down-counter and frame pulse
	// ------------------------------

	// Disabled: hold at the load value so the first frame is full length
	// Enabled: count down to one, then reload from the shadow
	// freq_tc is registered, high in the cycle after the counter hit one
	// First pulse P cycles after enable rises, then every P cycles
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			period_cnt <= '0;
			freq_tc    <= 1'b0;
		end
		else
		begin
			freq_tc <= enable && period_end;

			if (!enable)
				period_cnt <= period_val;
			else if (period_end)
				period_cnt <= period_shadow;
			else
				period_cnt <= period_cnt - CNT_ONE;
		end
	end

endmodule

/* src/duty_cycle_count.sv */
// PWM duty cycle counter
`timescale 1ns/1ps
`include "pwm_defs.svh"

module duty_cycle_count
	import pwm_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     enable,
	input  logic     idle_pol,
	input  logic     commit,
	input  pwm_cnt_t duty_val,
	input  logic     freq_tc,
	output logic     pwm
);

	// Counter is split into two bytes for a short carry path
	localparam int BYTE_W = `PWM_CNT_W / 2;

	duty_state_t       duty_state;
	duty_state_t       duty_state_nxt;

	// Duty in use, follows duty_val only on commit or while disabled
	pwm_cnt_t          duty_shadow;

	// Low byte counts every cycle, high byte on low byte wrap
	logic [BYTE_W-1:0] lo_cnt;
	logic [BYTE_W-1:0] lo_cnt_nxt;
	logic [BYTE_W-1:0] hi_cnt;
	logic [BYTE_W-1:0] hi_cnt_nxt;

	// Registered per-byte zero flags
	logic              lo_tc;
	logic              lo_tc_nxt;
	logic              hi_tc;
	logic              hi_tc_nxt;

	logic              cnt_ld;
	logic              cnt_done;
	logic              pwm_raw;

	// Whole counter at zero, both flags already registered
	assign cnt_done = lo_tc & hi_tc;

	// Reload outside count, at every frame boundary, and once the count runs out
	assign cnt_ld = (duty_state != duty_count) || freq_tc || cnt_done;

	// Idle polarity flips the pin, pwm_raw stays active high
	assign pwm = idle_pol ? ~pwm_raw : pwm_raw;

	// ------------------------------
	// Registers
	// ------------------------------

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			duty_state  <= duty_idle;
			duty_shadow <= '0;
			lo_cnt      <= '0;
			lo_tc       <= 1'b0;
			hi_cnt      <= '0;
			hi_tc       <= 1'b0;
			pwm_raw     <= 1'b0;
		end
		else
		begin
			duty_state <= duty_state_nxt;

			// Frame-safe update of the duty value
			if (!enable || commit)
				duty_shadow <= duty_val;

			lo_cnt <= lo_cnt_nxt;
			lo_tc  <= lo_tc_nxt;

			// High byte moves on a load or when the low byte wraps
			if (cnt_ld || lo_tc)
			begin
				hi_cnt <= hi_cnt_nxt;
				hi_tc  <= hi_tc_nxt;
			end

			// Output stage sits one cycle behind the state register
			// so the active run is exactly the time spent in count
			pwm_raw <= enable && (duty_state == duty_count);
		end
	end

	// ------------------------------
	// Byte counters
	// ------------------------------

	// Each flag is set one cycle early so it is true while its byte is zero
	always_comb
	begin
		if (cnt_ld)
		begin
			lo_cnt_nxt = duty_shadow[BYTE_W-1:0];
			lo_tc_nxt  = (duty_shadow[BYTE_W-1:0] == '0);
			hi_cnt_nxt = duty_shadow[2*BYTE_W-1:BYTE_W];
			hi_tc_nxt  = (duty_shadow[2*BYTE_W-1:BYTE_W] == '0);
		end
		else
		begin
			lo_cnt_nxt = lo_cnt - 1'b1;
			lo_tc_nxt  = (lo_cnt == BYTE_W'(1));
			hi_cnt_nxt = hi_cnt - 1'b1;
			hi_tc_nxt  = (hi_cnt == BYTE_W'(1));
		end
	end

	// ------------------------------
	// Duty FSM
	// ------------------------------

	// Count lasts D+1 cycles from each frame start, then wait for freq_tc
	// Duty at or above the period never reaches wait, output stays active
	always_comb
	begin
		duty_state_nxt = duty_state;

		case (duty_state)
		duty_idle:
		begin
			// Counter is already loaded, start the first frame
			if (enable)
				duty_state_nxt = duty_count;
		end
		duty_count:
		begin
			case ({enable, freq_tc, cnt_done})
			// Still counting down
			3'b100:
				duty_state_nxt = duty_count;
			// Ran out before the frame ended
			3'b101:
				duty_state_nxt = duty_wait;
			// Frame ended first or together, carry on with a fresh count
			3'b110,
			3'b111:
				duty_state_nxt = duty_count;
			// Disabled
			default:
				duty_state_nxt = duty_idle;
			endcase
		end
		duty_wait:
		begin
			if (!enable)
				duty_state_nxt = duty_idle;
			else if (freq_tc)
				duty_state_nxt = duty_count;
		end
		// Unused encoding, recover to idle
		default:
			duty_state_nxt = duty_idle;
		endcase
	end

endmodule

/* src/pwm_top.sv */
// PWM generator top level
`timescale 1ns/1ps
`include "pwm_defs.svh"

module pwm_top
	import pwm_pkg::*;
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   wr_en,
	input  logic [`PWM_ADDR_W-1:0] wr_addr,
	input  pwm_cnt_t               wr_data,
	output logic                   pwm
);

	// Register block outputs
	logic     enable;
	logic     idle_pol;
	logic     commit;
	pwm_cnt_t period_val;
	pwm_cnt_t duty_val;

	// Last cycle of each frame
	logic     freq_tc;

	// Write to enable, first active output three cycles later
	pwm_regs u_regs (
		.CLK        (CLK),
		.RST        (RST),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.enable     (enable),
		.idle_pol   (idle_pol),
		.period_val (period_val),
		.duty_val   (duty_val),
		.commit     (commit)
	);

	period_counter u_period (
		.CLK        (CLK),
		.RST        (RST),
		.enable     (enable),
		.commit     (commit),
		.period_val (period_val),
		.freq_tc    (freq_tc)
	);

	duty_cycle_count u_duty (
		.CLK      (CLK),
		.RST      (RST),
		.enable   (enable),
		.idle_pol (idle_pol),
		.commit   (commit),
		.duty_val (duty_val),
		.freq_tc  (freq_tc),
		.pwm      (pwm)
	);

endmodule

/* verification/pwm_tb.sv */
// PWM generator testbench
`timescale 1ns/1ps
`include "pwm_defs.svh"

module pwm_tb
	import pwm_pkg::*;
();

	// Largest random period, sets the run limit
	localparam int MAX_PERIOD     = 67;
	localparam int TIMEOUT_CYCLES = 40 * MAX_PERIOD + 200;

	// DUT inputs, all set before time zero
	logic                   CLK     = 1'b0;
	logic                   RST     = 1'b1;
	logic                   wr_en   = 1'b0;
	logic [`PWM_ADDR_W-1:0] wr_addr = '0;
	pwm_cnt_t               wr_data = '0;
	logic                   pwm;

	// Expected frame and the idle level in use
	int   exp_len     = 0;
	int   exp_high    = 0;
	int   skip_frames = 0;
	logic exp_pol     = 1'b0;

	// Check windows opened by the stimulus
	logic meas_en    = 1'b0;
	logic idle_chk   = 1'b0;
	logic active_chk = 1'b0;

	// Run length measurement, all updated on the falling edge
	logic pwm_s       = 1'b0;
	logic act_s       = 1'b0;
	logic prev_act    = 1'b0;
	logic have_rise   = 1'b0;
	logic frame_chk   = 1'b0;
	int   since_rise  = 0;
	int   high_run    = 0;
	int   meas_len    = 0;
	int   meas_high   = 0;
	int   frames_seen = 0;

	int          frames_checked  = 0;
	int          err_cnt         = 0;
	int          assert_fail_cnt = 0;
	int          cycle_cnt       = 0;
	int          cur_period      = 0;
	logic [31:0] lfsr            = 32'h5c4d;

	pwm_top u_pwm_top (
		.CLK     (CLK),
		.RST     (RST),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.pwm     (pwm)
	);

	// 20 ns clock
	always #10 CLK = ~CLK;

	// ------------------------------
	// Helpers
	// ------------------------------

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic int take_bits(input int nbits);
		int   val;
		int   i;
		logic fb;
		val = 0;
		for (i = 0; i < nbits; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = (val << 1) | int'(fb);
		end
		return val;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int want);
		assert_fail_cnt++;
		$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
	endtask

	// Ends 1 ns after the n-th rising edge
	task automatic step(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	// One-cycle write strobe
	task automatic write_reg(input reg_addr_t addr, input int value);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = pwm_cnt_t'(value);
		step(1);
		wr_en   = 1'b0;
	endtask

	// Hold the idle level for n cycles, starting two cycles from now
	task automatic check_idle(input int n);
		step(2);
		idle_chk = 1'b1;
		step(n);
		idle_chk = 1'b0;
	endtask

	// Active run is min(D+1, P), a full run means the pin never drops
	task automatic check_setting(input int period, input int duty, input int skip,
		input int count);
		int hi_exp;
		hi_exp = (duty + 1 < period) ? duty + 1 : period;
		if (hi_exp >= period)
		begin
			// Let the old frame and one new frame pass
			step(cur_period + period + 4);
			active_chk = 1'b1;
			step(count * period);
			active_chk = 1'b0;
		end
		else
		begin
			meas_en     = 1'b0;
			exp_len     = period;
			exp_high    = hi_exp;
			skip_frames = skip;
			step(1);
			meas_en = 1'b1;
			while (frames_seen < skip + count)
				step(1);
			meas_en = 1'b0;
		end
		cur_period = period;
	endtask

	// ------------------------------
	// Measurement
	// ------------------------------

	// Sampled mid-cycle, frames are cut at each rise of the active level
	always @(negedge CLK)
	begin
		pwm_s     = pwm;
		act_s     = pwm ^ exp_pol;
		frame_chk = 1'b0;
		if (!meas_en)
		begin
			have_rise   = 1'b0;
			since_rise  = 0;
			frames_seen = 0;
		end
		else if (act_s && !prev_act)
		begin
			// First rise only marks the start
			if (have_rise)
			begin
				meas_len    = since_rise;
				meas_high   = high_run;
				frames_seen = frames_seen + 1;
				frame_chk   = (frames_seen > skip_frames);
				if (frame_chk)
					frames_checked++;
			end
			have_rise  = 1'b1;
			since_rise = 1;
		end
		else
		begin
			if (!act_s && prev_act)
				high_run = since_rise;
			since_rise = since_rise + 1;
		end
		prev_act = act_s;
	end

	// Checked on the rising edge, all inputs settled at the falling edge
	a_frame_len: assert property (@(posedge CLK) disable iff (RST)
		frame_chk |-> (meas_len == exp_len))
		else report_mismatch("pwm frame length", meas_len, exp_len);

	a_high_run: assert property (@(posedge CLK) disable iff (RST)
		frame_chk |-> (meas_high == exp_high))
		else report_mismatch("pwm active run", meas_high, exp_high);

	a_idle: assert property (@(posedge CLK) disable iff (RST)
		idle_chk |-> (pwm_s == exp_pol))
		else report_mismatch("pwm", int'(pwm_s), int'(exp_pol));

	a_active: assert property (@(posedge CLK) disable iff (RST)
		active_chk |-> (pwm_s == !exp_pol))
		else report_mismatch("pwm", int'(pwm_s), int'(!exp_pol));

	// Watchdog
	always @(posedge CLK)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			err_cnt++;
			$display("timeout after %0d cycles, the pwm frames did not complete", cycle_cnt);
			$display("errors %0d, assertion failures %0d", err_cnt, assert_fail_cnt);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial
	begin
		int i;
		int p;
		int d;

		repeat (4) @(posedge CLK);
		#1;
		RST = 1'b0;

		// Idle level after reset, then with inverted polarity
		check_idle(20);
		write_reg(reg_ctrl, 2);
		exp_pol = 1'b1;
		check_idle(20);
		write_reg(reg_ctrl, 0);
		exp_pol = 1'b0;
		check_idle(4);

		// Fixed frame
		write_reg(reg_period, 10);
		write_reg(reg_duty, 3);
		write_reg(reg_commit, 0);
		write_reg(reg_ctrl, 1);
		cur_period = 10;
		check_setting(10, 3, 0, 5);

		// Uncommitted values stay in the value registers
		write_reg(reg_period, 16);
		write_reg(reg_duty, 9);
		check_setting(10, 3, 0, 3);
		write_reg(reg_commit, 0);
		check_setting(16, 9, 1, 3);

		// Random pairs, duty below period
		for (i = 0; i < 8; i++)
		begin
			p = 4 + take_bits(6);
			d = take_bits(7) % p;
			write_reg(reg_period, p);
			write_reg(reg_duty, d);
			write_reg(reg_commit, 0);
			check_setting(p, d, 1, 2);
		end

		// Duty edges, full period, far above the period, zero
		write_reg(reg_period, 20);
		write_reg(reg_duty, 19);
		write_reg(reg_commit, 0);
		check_setting(20, 19, 1, 3);
		write_reg(reg_duty, 300);
		write_reg(reg_commit, 0);
		check_setting(20, 300, 1, 3);
		write_reg(reg_duty, 0);
		write_reg(reg_commit, 0);
		check_setting(20, 0, 1, 3);

		// Disable, then the fixed frame again with idle high
		write_reg(reg_ctrl, 0);
		check_idle(40);
		write_reg(reg_period, 10);
		write_reg(reg_duty, 3);
		exp_pol = 1'b1;
		write_reg(reg_ctrl, 3);
		cur_period = 10;
		check_setting(10, 3, 0, 5);
		write_reg(reg_ctrl, 2);
		check_idle(40);

		if (frames_checked == 0)
		begin
			err_cnt++;
			$display("no pwm frames were measured");
		end

		$display("errors %0d, assertion failures %0d", err_cnt, assert_fail_cnt);
		if (err_cnt == 0 && assert_fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/pwm_pkg.sv
src/pwm_regs.sv
src/period_counter.sv
src/duty_cycle_count.sv
src/pwm_top.sv
verification/pwm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PWM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
	-f sources.f \
	--top-module pwm_tb \
	-o pwm_sim

./obj_dir/pwm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
